//--- source/tti_macros.svh
// Data, queue and timeout widths, register byte addresses
// and interrupt bit positions
`ifndef TTI_MACROS_SVH
`define TTI_MACROS_SVH

`define TTI_DATA_W      32
`define TTI_QUEUE_DEPTH 8
`define TTI_LEVEL_W     4
`define TTI_TIMEOUT_W   16
`define TTI_ADDR_W      6

`define TTI_A_IRQ_STATUS   6'h00
`define TTI_A_IRQ_ENABLE   6'h04
`define TTI_A_IRQ_FORCE    6'h08
`define TTI_A_THLD_CTRL    6'h0C
`define TTI_A_RESET_CTRL   6'h10
`define TTI_A_TIMEOUT_CTRL 6'h14
`define TTI_A_QUEUE_STATUS 6'h18
`define TTI_A_RX_DESC_PORT 6'h1C
`define TTI_A_RX_DATA_PORT 6'h20
`define TTI_A_TX_DATA_PORT 6'h24

`define TTI_IRQ_RX_DESC          0
`define TTI_IRQ_RX_DESC_THLD     1
`define TTI_IRQ_RX_DATA_THLD     2
`define TTI_IRQ_TX_DESC_COMPLETE 3
`define TTI_IRQ_RX_DESC_TIMEOUT  4
`define TTI_IRQ_N                5

`endif

//--- source/tti_reg_pkg.sv
// Register-side types: CSR word, register address, interrupt vector,
// bus state machine states
`default_nettype none

`include "tti_macros.svh"

package tti_reg_pkg;

  typedef logic [`TTI_DATA_W-1:0] csr_word_t;
  typedef logic [`TTI_ADDR_W-1:0] reg_addr_t;
  typedef logic [`TTI_IRQ_N-1:0]  irq_vec_t;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACCESS,
    BUS_ACK
  } bus_state_e;

endpackage

`default_nettype wire

//--- source/tti_queue_pkg.sv
// Queue-side types: entry word, fill level, threshold
`default_nettype none

`include "tti_macros.svh"

package tti_queue_pkg;

  typedef logic [`TTI_DATA_W-1:0]  queue_word_t;
  typedef logic [`TTI_LEVEL_W-1:0] queue_level_t;
  typedef logic [`TTI_LEVEL_W-1:0] queue_thld_t;

endpackage

`default_nettype wire

//--- source/tti_bus_fsm.sv
// Wishbone classic slave FSM producing register and queue strobes
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_bus_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  tti_reg_pkg::reg_addr_t wb_adr_i,
  input  tti_reg_pkg::csr_word_t wb_dat_i,
  output tti_reg_pkg::csr_word_t wb_dat_o,
  output logic                   wb_ack_o,
  input  logic                   tx_full_i,
  input  logic                   rx_desc_empty_i,
  input  logic                   rx_data_empty_i,
  input  tti_reg_pkg::csr_word_t rdata_i,
  output logic                   reg_wr_o,
  output logic                   reg_rd_o,
  output tti_reg_pkg::reg_addr_t addr_o,
  output tti_reg_pkg::csr_word_t wdata_o,
  output logic                   rx_desc_pop_o,
  output logic                   rx_data_pop_o,
  output logic                   tx_data_push_o
);

  tti_reg_pkg::bus_state_e state_q, state_d;
  logic is_rx_desc;
  logic is_rx_data;
  logic is_tx_data;
  logic stall;
  logic access;

  assign is_rx_desc = (wb_adr_i == `TTI_A_RX_DESC_PORT);
  assign is_rx_data = (wb_adr_i == `TTI_A_RX_DATA_PORT);
  assign is_tx_data = (wb_adr_i == `TTI_A_TX_DATA_PORT);

  // Hold the cycle until the TX queue has room
  assign stall  = wb_we_i & is_tx_data & tx_full_i;
  assign access = (state_q == tti_reg_pkg::BUS_ACCESS) & ~stall;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      tti_reg_pkg::BUS_IDLE: begin
        if (wb_cyc_i && wb_stb_i) begin
          state_d = tti_reg_pkg::BUS_ACCESS;
        end
      end
      tti_reg_pkg::BUS_ACCESS: begin
        if (!stall) begin
          state_d = tti_reg_pkg::BUS_ACK;
        end
      end
      default: state_d = tti_reg_pkg::BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tti_reg_pkg::BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign reg_wr_o       = access & wb_we_i;
  assign reg_rd_o       = access & ~wb_we_i;
  assign rx_desc_pop_o  = reg_rd_o & is_rx_desc & ~rx_desc_empty_i;
  assign rx_data_pop_o  = reg_rd_o & is_rx_data & ~rx_data_empty_i;
  assign tx_data_push_o = reg_wr_o & is_tx_data;
  assign addr_o         = wb_adr_i;
  assign wdata_o        = wb_dat_i;
  assign wb_ack_o       = (state_q == tti_reg_pkg::BUS_ACK);

  always_ff @(posedge clk_i) begin
    if (reg_rd_o) begin
      wb_dat_o <= rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- source/tti_csr_regs.sv
// Threshold and timeout registers, flush decode, read-data mux
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_csr_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        reg_wr_i,
  input  tti_reg_pkg::reg_addr_t      addr_i,
  input  tti_reg_pkg::csr_word_t      wdata_i,
  input  tti_reg_pkg::irq_vec_t       irq_status_i,
  input  tti_reg_pkg::irq_vec_t       irq_enable_i,
  input  logic [5:0]                  queue_flags_i,
  input  tti_queue_pkg::queue_word_t  rx_desc_head_i,
  input  tti_queue_pkg::queue_word_t  rx_data_head_i,
  output tti_reg_pkg::csr_word_t      rdata_o,
  output tti_queue_pkg::queue_thld_t  rx_desc_thld_o,
  output tti_queue_pkg::queue_thld_t  rx_data_thld_o,
  output logic [`TTI_TIMEOUT_W-1:0]   timeout_o,
  output logic [2:0]                  flush_o
);

  tti_queue_pkg::queue_thld_t rx_desc_thld_q;
  tti_queue_pkg::queue_thld_t rx_data_thld_q;
  logic [`TTI_TIMEOUT_W-1:0]  timeout_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_desc_thld_q <= '0;
      rx_data_thld_q <= '0;
      timeout_q      <= '0;
    end else if (reg_wr_i) begin
      if (addr_i == `TTI_A_THLD_CTRL) begin
        rx_desc_thld_q <= wdata_i[`TTI_LEVEL_W-1:0];
        rx_data_thld_q <= wdata_i[8 +: `TTI_LEVEL_W];
      end
      if (addr_i == `TTI_A_TIMEOUT_CTRL) begin
        timeout_q <= wdata_i[`TTI_TIMEOUT_W-1:0];
      end
    end
  end

  // Bit per queue: RX desc, RX data, TX data
  assign flush_o = (reg_wr_i && addr_i == `TTI_A_RESET_CTRL) ? wdata_i[2:0] : 3'b000;

  assign rx_desc_thld_o = rx_desc_thld_q;
  assign rx_data_thld_o = rx_data_thld_q;
  assign timeout_o      = timeout_q;

  always_comb begin
    rdata_o = '0;
    unique case (addr_i)
      `TTI_A_IRQ_STATUS:   rdata_o = tti_reg_pkg::csr_word_t'(irq_status_i);
      `TTI_A_IRQ_ENABLE:   rdata_o = tti_reg_pkg::csr_word_t'(irq_enable_i);
      `TTI_A_THLD_CTRL: begin
        rdata_o[`TTI_LEVEL_W-1:0]  = rx_desc_thld_q;
        rdata_o[8 +: `TTI_LEVEL_W] = rx_data_thld_q;
      end
      `TTI_A_TIMEOUT_CTRL: rdata_o = tti_reg_pkg::csr_word_t'(timeout_q);
      `TTI_A_QUEUE_STATUS: rdata_o = tti_reg_pkg::csr_word_t'(queue_flags_i);
      // Empty queues read as zero
      `TTI_A_RX_DESC_PORT: rdata_o = queue_flags_i[0] ? '0 : rx_desc_head_i;
      `TTI_A_RX_DATA_PORT: rdata_o = queue_flags_i[2] ? '0 : rx_data_head_i;
      default:             rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/tti_queue.sv
// Synchronous FIFO with fill level, threshold trigger and flush
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_queue #(
  parameter int unsigned Depth = `TTI_QUEUE_DEPTH
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         push_i,
  input  tti_queue_pkg::queue_word_t   data_i,
  input  logic                         pop_i,
  input  logic                         flush_i,
  input  tti_queue_pkg::queue_thld_t   thld_i,
  output tti_queue_pkg::queue_word_t   head_o,
  output tti_queue_pkg::queue_level_t  level_o,
  output logic                         empty_o,
  output logic                         full_o,
  output logic                         thld_trig_o
);

  localparam int unsigned PtrW = $clog2(Depth);

  tti_queue_pkg::queue_word_t  mem_q [Depth];
  logic [PtrW-1:0]             wr_ptr_q;
  logic [PtrW-1:0]             rd_ptr_q;
  tti_queue_pkg::queue_level_t level_q;
  logic                        do_push;
  logic                        do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      level_q <= level_q + tti_queue_pkg::queue_level_t'(do_push)
                         - tti_queue_pkg::queue_level_t'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign head_o      = mem_q[rd_ptr_q];
  assign level_o     = level_q;
  assign empty_o     = (level_q == '0);
  assign full_o      = (level_q == tti_queue_pkg::queue_level_t'(Depth));
  // Zero threshold disables the trigger
  assign thld_trig_o = (thld_i != '0) && (level_q >= thld_i);

endmodule

`default_nettype wire

//--- source/tti_irq_ctrl.sv
// Sticky interrupt status with set, force, enable, write-one-to-clear
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_irq_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_wr_i,
  input  tti_reg_pkg::reg_addr_t addr_i,
  input  tti_reg_pkg::csr_word_t wdata_i,
  input  logic                   rx_desc_push_i,
  input  logic                   rx_desc_thld_trig_i,
  input  logic                   rx_data_push_i,
  input  logic                   rx_data_thld_trig_i,
  input  logic                   rx_desc_pop_i,
  input  logic                   rx_data_pop_i,
  input  logic                   tx_pr_end_i,
  input  logic                   timeout_i,
  output tti_reg_pkg::irq_vec_t  status_o,
  output tti_reg_pkg::irq_vec_t  enable_o,
  output logic                   irq_o
);

  tti_reg_pkg::irq_vec_t status_q;
  tti_reg_pkg::irq_vec_t enable_q;
  tti_reg_pkg::irq_vec_t set_vec;
  tti_reg_pkg::irq_vec_t clr_vec;
  tti_reg_pkg::irq_vec_t force_vec;
  tti_reg_pkg::irq_vec_t w1c_vec;
  logic                  rx_desc_push_q;
  logic                  rx_data_push_q;
  logic                  irq_q;

  always_comb begin
    set_vec = '0;
    clr_vec = '0;
    set_vec[`TTI_IRQ_RX_DESC]          = rx_desc_push_i;
    // Delayed push lines up with the updated trigger
    set_vec[`TTI_IRQ_RX_DESC_THLD]     = rx_desc_push_q & rx_desc_thld_trig_i;
    set_vec[`TTI_IRQ_RX_DATA_THLD]     = rx_data_push_q & rx_data_thld_trig_i;
    set_vec[`TTI_IRQ_TX_DESC_COMPLETE] = tx_pr_end_i;
    set_vec[`TTI_IRQ_RX_DESC_TIMEOUT]  = timeout_i;
    clr_vec[`TTI_IRQ_RX_DESC]          = rx_desc_pop_i;
    clr_vec[`TTI_IRQ_RX_DESC_THLD]     = rx_desc_pop_i;
    clr_vec[`TTI_IRQ_RX_DATA_THLD]     = rx_data_pop_i;
  end

  assign force_vec = (reg_wr_i && addr_i == `TTI_A_IRQ_FORCE) ?
                     wdata_i[`TTI_IRQ_N-1:0] : '0;
  assign w1c_vec   = (reg_wr_i && addr_i == `TTI_A_IRQ_STATUS) ?
                     wdata_i[`TTI_IRQ_N-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q       <= '0;
      enable_q       <= '0;
      rx_desc_push_q <= 1'b0;
      rx_data_push_q <= 1'b0;
      irq_q          <= 1'b0;
    end else begin
      // New causes win over clears in the same cycle
      status_q       <= (status_q & ~(clr_vec | w1c_vec)) | set_vec | force_vec;
      rx_desc_push_q <= rx_desc_push_i;
      rx_data_push_q <= rx_data_push_i;
      irq_q          <= |(status_q & enable_q);
      if (reg_wr_i && addr_i == `TTI_A_IRQ_ENABLE) begin
        enable_q <= wdata_i[`TTI_IRQ_N-1:0];
      end
    end
  end

  assign status_o = status_q;
  assign enable_o = enable_q;
  assign irq_o    = irq_q;

endmodule

`default_nettype wire

//--- source/tti_desc_timer.sv
// Timeout counter for an unread RX descriptor queue
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_desc_timer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      active_i,
  input  logic                      restart_i,
  input  logic [`TTI_TIMEOUT_W-1:0] limit_i,
  output logic                      expire_o
);

  logic [`TTI_TIMEOUT_W-1:0] count_q;
  logic                      running;

  // Zero limit keeps the timer off
  assign running  = active_i & ~restart_i & (limit_i != '0);
  assign expire_o = running & (count_q == limit_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (!running || expire_o) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + `TTI_TIMEOUT_W'(1);
    end
  end

endmodule

`default_nettype wire

//--- source/tti_top.sv
// Target transaction interface top: bus FSM, registers, three queues,
// descriptor timer and interrupt control
`timescale 1ns/1ps
`default_nettype none

`include "tti_macros.svh"

module tti_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  tti_reg_pkg::reg_addr_t     wb_adr_i,
  input  tti_reg_pkg::csr_word_t     wb_dat_i,
  output tti_reg_pkg::csr_word_t     wb_dat_o,
  output logic                       wb_ack_o,
  input  logic                       rx_desc_push_i,
  input  tti_queue_pkg::queue_word_t rx_desc_data_i,
  output logic                       rx_desc_full_o,
  input  logic                       rx_data_push_i,
  input  tti_queue_pkg::queue_word_t rx_data_data_i,
  output logic                       rx_data_full_o,
  input  logic                       tx_data_pop_i,
  output tti_queue_pkg::queue_word_t tx_data_data_o,
  output logic                       tx_data_empty_o,
  input  logic                       tx_pr_end_i,
  output logic                       irq_o
);

  logic                       reg_wr;
  tti_reg_pkg::reg_addr_t     addr;
  tti_reg_pkg::csr_word_t     wdata;
  tti_reg_pkg::csr_word_t     rdata;
  logic                       rx_desc_pop;
  logic                       rx_data_pop;
  logic                       tx_data_push;
  tti_reg_pkg::irq_vec_t      irq_status;
  tti_reg_pkg::irq_vec_t      irq_enable;
  tti_queue_pkg::queue_thld_t rx_desc_thld;
  tti_queue_pkg::queue_thld_t rx_data_thld;
  logic [`TTI_TIMEOUT_W-1:0]  timeout;
  logic [2:0]                 flush;
  tti_queue_pkg::queue_word_t rx_desc_head;
  tti_queue_pkg::queue_word_t rx_data_head;
  logic                       rx_desc_empty;
  logic                       rx_data_empty;
  logic                       tx_data_full;
  logic                       rx_desc_trig;
  logic                       rx_data_trig;
  logic                       desc_expire;
  logic [5:0]                 queue_flags;

  assign queue_flags = {tx_data_full, tx_data_empty_o, rx_data_full_o, rx_data_empty,
                        rx_desc_full_o, rx_desc_empty};

  tti_bus_fsm u_bus_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .tx_full_i       (tx_data_full),
    .rx_desc_empty_i (rx_desc_empty),
    .rx_data_empty_i (rx_data_empty),
    .rdata_i         (rdata),
    .reg_wr_o        (reg_wr),
    .reg_rd_o        (),
    .addr_o          (addr),
    .wdata_o         (wdata),
    .rx_desc_pop_o   (rx_desc_pop),
    .rx_data_pop_o   (rx_data_pop),
    .tx_data_push_o  (tx_data_push)
  );

  tti_csr_regs u_csr_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .reg_wr_i       (reg_wr),
    .addr_i         (addr),
    .wdata_i        (wdata),
    .irq_status_i   (irq_status),
    .irq_enable_i   (irq_enable),
    .queue_flags_i  (queue_flags),
    .rx_desc_head_i (rx_desc_head),
    .rx_data_head_i (rx_data_head),
    .rdata_o        (rdata),
    .rx_desc_thld_o (rx_desc_thld),
    .rx_data_thld_o (rx_data_thld),
    .timeout_o      (timeout),
    .flush_o        (flush)
  );

  tti_queue #(.Depth(`TTI_QUEUE_DEPTH)) u_rx_desc_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (rx_desc_push_i),
    .data_i      (rx_desc_data_i),
    .pop_i       (rx_desc_pop),
    .flush_i     (flush[0]),
    .thld_i      (rx_desc_thld),
    .head_o      (rx_desc_head),
    .level_o     (),
    .empty_o     (rx_desc_empty),
    .full_o      (rx_desc_full_o),
    .thld_trig_o (rx_desc_trig)
  );

  tti_queue #(.Depth(`TTI_QUEUE_DEPTH)) u_rx_data_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (rx_data_push_i),
    .data_i      (rx_data_data_i),
    .pop_i       (rx_data_pop),
    .flush_i     (flush[1]),
    .thld_i      (rx_data_thld),
    .head_o      (rx_data_head),
    .level_o     (),
    .empty_o     (rx_data_empty),
    .full_o      (rx_data_full_o),
    .thld_trig_o (rx_data_trig)
  );

  // No threshold on the TX side
  tti_queue #(.Depth(`TTI_QUEUE_DEPTH)) u_tx_data_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (tx_data_push),
    .data_i      (wdata),
    .pop_i       (tx_data_pop_i),
    .flush_i     (flush[2]),
    .thld_i      ('0),
    .head_o      (tx_data_data_o),
    .level_o     (),
    .empty_o     (tx_data_empty_o),
    .full_o      (tx_data_full),
    .thld_trig_o ()
  );

  tti_desc_timer u_desc_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .active_i  (~rx_desc_empty),
    .restart_i (rx_desc_pop),
    .limit_i   (timeout),
    .expire_o  (desc_expire)
  );

  tti_irq_ctrl u_irq_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_wr_i            (reg_wr),
    .addr_i              (addr),
    .wdata_i             (wdata),
    .rx_desc_push_i      (rx_desc_push_i),
    .rx_desc_thld_trig_i (rx_desc_trig),
    .rx_data_push_i      (rx_data_push_i),
    .rx_data_thld_trig_i (rx_data_trig),
    .rx_desc_pop_i       (rx_desc_pop),
    .rx_data_pop_i       (rx_data_pop),
    .tx_pr_end_i         (tx_pr_end_i),
    .timeout_i           (desc_expire),
    .status_o            (irq_status),
    .enable_o            (irq_enable),
    .irq_o               (irq_o)
  );

endmodule

`default_nettype wire

//--- testbench/tti_chk.sv
// Concurrent checks on ack pulse, queue pop and push rules, irq_o
`timescale 1ns/1ps
`default_nettype none

module tti_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  wb_ack_i,
  input logic                  rx_desc_pop_i,
  input logic                  rx_desc_empty_i,
  input logic                  rx_data_pop_i,
  input logic                  rx_data_empty_i,
  input logic                  tx_data_pop_i,
  input logic                  tx_data_empty_i,
  input logic                  rx_desc_push_i,
  input logic                  rx_desc_full_i,
  input logic                  rx_data_push_i,
  input logic                  rx_data_full_i,
  input tti_reg_pkg::irq_vec_t irq_status_i,
  input tti_reg_pkg::irq_vec_t irq_enable_i,
  input logic                  irq_i
);

  int fail_count = 0;

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
  else begin
    $error("wb_ack_o stayed high for more than one cycle");
    fail_count++;
  end

  no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_desc_pop_i && rx_desc_empty_i) || (rx_data_pop_i && rx_data_empty_i) ||
      (tx_data_pop_i && tx_data_empty_i)))
  else begin
    $error("A queue was popped while empty");
    fail_count++;
  end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_desc_push_i && rx_desc_full_i) || (rx_data_push_i && rx_data_full_i)))
  else begin
    $error("The target pushed into a full RX queue");
    fail_count++;
  end

  // irq_o is registered, so it follows one cycle later
  irq_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (~|(irq_status_i & irq_enable_i)) |=> !irq_i)
  else begin
    $error("irq_o high with no enabled status bit");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- testbench/tti_tb.sv
// Vector-driven testbench for the target transaction interface:
// Wishbone master, target-side stimulus, result checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tti_tb;

  localparam int unsigned Seed            = 32'hf639_69bd;
  localparam int          AckLimit        = 64;
  localparam int          StallCycles     = 10;
  localparam int          CyclesPerVector = 200;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       wb_cyc_i;
  logic                       wb_stb_i;
  logic                       wb_we_i;
  tti_reg_pkg::reg_addr_t     wb_adr_i;
  tti_reg_pkg::csr_word_t     wb_dat_i;
  tti_reg_pkg::csr_word_t     wb_dat_o;
  logic                       wb_ack_o;
  logic                       rx_desc_push_i;
  tti_queue_pkg::queue_word_t rx_desc_data_i;
  logic                       rx_desc_full_o;
  logic                       rx_data_push_i;
  tti_queue_pkg::queue_word_t rx_data_data_i;
  logic                       rx_data_full_o;
  logic                       tx_data_pop_i;
  tti_queue_pkg::queue_word_t tx_data_data_o;
  logic                       tx_data_empty_o;
  logic                       tx_pr_end_i;
  logic                       irq_o;

  // One entry per vector line
  logic [7:0]  vec_op  [$];
  logic [31:0] vec_adr [$];
  logic [31:0] vec_dat [$];
  logic [31:0] vec_exp [$];
  int          errors;
  int          checks;
  bit          vectors_loaded;

  tti_top u_tti_top (.*);

  bind tti_top tti_chk u_tti_chk (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_ack_i        (wb_ack_o),
    .rx_desc_pop_i   (rx_desc_pop),
    .rx_desc_empty_i (rx_desc_empty),
    .rx_data_pop_i   (rx_data_pop),
    .rx_data_empty_i (rx_data_empty),
    .tx_data_pop_i   (tx_data_pop_i),
    .tx_data_empty_i (tx_data_empty_o),
    .rx_desc_push_i  (rx_desc_push_i),
    .rx_desc_full_i  (rx_desc_full_o),
    .rx_data_push_i  (rx_data_push_i),
    .rx_data_full_i  (rx_data_full_o),
    .irq_status_i    (irq_status),
    .irq_enable_i    (irq_enable),
    .irq_i           (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic start_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr[5:0];
    wb_dat_i = dat;
  endtask

  // Wait for the acknowledge, then release the bus for one cycle
  task automatic finish_cycle(input logic [31:0] adr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!wb_ack_o && waited < AckLimit) begin
      @(negedge clk_i);
      waited++;
    end
    checks++;
    assert (wb_ack_o) else begin
      $display("Bus cycle to address 0x%h got no acknowledge", adr[5:0]);
      errors++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic pop_tx(input logic [31:0] exp);
    checks++;
    assert (!tx_data_empty_o) else begin
      $display("Target pop requested while the TX queue is empty");
      errors++;
    end
    if (!tx_data_empty_o) begin
      compare_value("tx_data_data_o", tx_data_data_o, exp);
      tx_data_pop_i = 1'b1;
      @(negedge clk_i);
      tx_data_pop_i = 1'b0;
    end
  endtask

  // TX queue is full, so no ack may come until the target pops
  task automatic write_into_full_tx(input logic [31:0] adr, input logic [31:0] dat,
                                    input logic [31:0] exp);
    start_cycle(1'b1, adr, dat);
    repeat (StallCycles) begin
      @(negedge clk_i);
      checks++;
      assert (!wb_ack_o) else begin
        $display("Write to the full TX queue was acknowledged before any pop");
        errors++;
      end
    end
    pop_tx(exp);
    finish_cycle(adr);
  endtask

  task automatic push_rx(input logic to_desc, input logic [31:0] dat);
    checks++;
    assert (!(to_desc ? rx_desc_full_o : rx_data_full_o)) else begin
      $display("RX queue full, push skipped");
      errors++;
    end
    if (to_desc && !rx_desc_full_o) begin
      rx_desc_push_i = 1'b1;
      rx_desc_data_i = dat;
    end else if (!to_desc && !rx_data_full_o) begin
      rx_data_push_i = 1'b1;
      rx_data_data_i = dat;
    end
    @(negedge clk_i);
    rx_desc_push_i = 1'b0;
    rx_data_push_i = 1'b0;
  endtask

  // Status sets one edge after its cause and irq_o one edge later
  task automatic check_irq(input logic [31:0] exp);
    repeat (2) @(negedge clk_i);
    compare_value("irq_o", {31'b0, irq_o}, exp);
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    errors         = 0;
    checks         = 0;
    vectors_loaded = 1'b0;
    rst_ni         = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    rx_desc_push_i = 1'b0;
    rx_desc_data_i = '0;
    rx_data_push_i = 1'b0;
    rx_data_data_i = '0;
    tx_data_pop_i  = 1'b0;
    tx_pr_end_i    = 1'b0;
    void'($urandom(Seed));

    fd = $fopen("testbench/tti_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file testbench/tti_vectors.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%c %h %h %h", op, adr, dat, exp);
          if (fields == 4) begin
            vec_op.push_back(op);
            vec_adr.push_back(adr);
            vec_dat.push_back(dat);
            vec_exp.push_back(exp);
          end
        end
      end
      $fclose(fd);
    end
    if (fd != 0 && vec_op.size() == 0) begin
      $display("The vector file holds no usable lines");
      errors++;
    end
    vectors_loaded = 1'b1;

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int idx = 0; idx < vec_op.size(); idx++) begin
      repeat ($urandom_range(3, 0)) @(negedge clk_i);
      case (vec_op[idx])
        "W": begin
          start_cycle(1'b1, vec_adr[idx], vec_dat[idx]);
          finish_cycle(vec_adr[idx]);
        end
        "R": begin
          start_cycle(1'b0, vec_adr[idx], '0);
          finish_cycle(vec_adr[idx]);
          compare_value($sformatf("wb_dat_o (address 0x%h)", vec_adr[idx][5:0]),
                        wb_dat_o, vec_exp[idx]);
        end
        "B": write_into_full_tx(vec_adr[idx], vec_dat[idx], vec_exp[idx]);
        "P": push_rx(1'b1, vec_dat[idx]);
        "D": push_rx(1'b0, vec_dat[idx]);
        "T": pop_tx(vec_exp[idx]);
        "E": begin
          tx_pr_end_i = 1'b1;
          @(negedge clk_i);
          tx_pr_end_i = 1'b0;
        end
        "Q": check_irq(vec_exp[idx]);
        "C": repeat (vec_dat[idx]) @(negedge clk_i);
        default: begin
          $display("Unknown operation in vector %0d", idx);
          errors++;
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_tti_top.u_tti_chk.fail_count);
    if (errors == 0 && u_tti_top.u_tti_chk.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Budget grows with the number of vector lines
  initial begin
    wait (vectors_loaded);
    repeat (CyclesPerVector * (vec_op.size() + 1)) @(posedge clk_i);
    $display("Watchdog expired, the run did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tti_vectors.txt
# op addr data expect, all hex; W write, R read, B write into a full TX queue
# P/D push RX desc/data, T pop TX, E private read end, Q irq_o, C idle cycles
R 18 0 15
R 00 0 0
Q 0 0 0
# RX words in push order, empty reads give zero
P 0 a1a1a101 0
P 0 a1a1a102 0
D 0 d0d0d001 0
D 0 d0d0d002 0
R 18 0 10
R 1c 0 a1a1a101
R 1c 0 a1a1a102
R 20 0 d0d0d001
R 20 0 d0d0d002
R 1c 0 0
R 20 0 0
R 18 0 15
R 00 0 0
# TX fill, stalled ninth write, drain
W 24 70000001 0
W 24 70000002 0
W 24 70000003 0
W 24 70000004 0
W 24 70000005 0
W 24 70000006 0
W 24 70000007 0
W 24 70000008 0
R 18 0 25
B 24 70000009 70000001
T 0 0 70000002
T 0 0 70000003
T 0 0 70000004
T 0 0 70000005
T 0 0 70000006
T 0 0 70000007
T 0 0 70000008
T 0 0 70000009
R 18 0 15
# Thresholds of 3
W 0c 303 0
R 0c 0 303
W 04 6 0
P 0 b0000001 0
P 0 b0000002 0
R 00 0 1
Q 0 0 0
P 0 b0000003 0
R 00 0 3
Q 0 0 1
R 1c 0 b0000001
R 00 0 0
Q 0 0 0
D 0 c0000001 0
D 0 c0000002 0
R 00 0 0
D 0 c0000003 0
R 00 0 4
Q 0 0 1
R 20 0 c0000001
R 00 0 0
Q 0 0 0
# Per-queue flush
R 18 0 10
W 10 1 0
R 18 0 11
R 1c 0 0
W 10 2 0
R 18 0 15
R 20 0 0
W 24 5a5a5a5a 0
R 18 0 05
W 10 4 0
R 18 0 15
# Private read end, force, enable, write-one-to-clear
E 0 0 0
R 00 0 8
Q 0 0 0
W 08 11 0
R 00 0 19
W 04 8 0
Q 0 0 1
W 00 9 0
R 00 0 10
Q 0 0 0
W 00 10 0
R 00 0 0
# Descriptor timeout of 20 cycles
W 14 14 0
P 0 e0000001 0
C 0 0d 0
R 00 0 1
C 0 05 0
R 00 0 11
W 04 10 0
Q 0 0 1
R 1c 0 e0000001
W 14 0 0
W 00 10 0
R 00 0 0
Q 0 0 0

//--- project.f
+incdir+source
source/tti_reg_pkg.sv
source/tti_queue_pkg.sv
source/tti_bus_fsm.sv
source/tti_csr_regs.sv
source/tti_queue.sv
source/tti_irq_ctrl.sv
source/tti_desc_timer.sv
source/tti_top.sv
testbench/tti_chk.sv
testbench/tti_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
  --top-module tti_tb -o tti_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tti_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log && exit 0 || exit 1
